//--- rtl/burst_coal_cfg.svh
/* widths, FIFO depths, almost-full cutoffs and the idle timeout
   shared by the burst coalescer */
`ifndef BURST_COAL_CFG_SVH
`define BURST_COAL_CFG_SVH

// word address and Avalon burst count widths
`define BC_WORD_ADDR_W          16
`define BC_BURSTCOUNT_W         5

// bursts never cross a boundary of this many words, 2**(burstcount width - 1)
`define BC_MAX_BURST            (1 << (`BC_BURSTCOUNT_W - 1))

// the adder carry chain is cut here, never below the burst count width so
// that all words of one burst share the same upper half
`define BC_TESS_INDEX           (((`BC_WORD_ADDR_W / 2) < `BC_BURSTCOUNT_W) ? \
                                 `BC_BURSTCOUNT_W : (`BC_WORD_ADDR_W / 2))

`define BC_UPSTREAM_STALL_LAT   0       // cycles from almost-full to the last input valid
`define BC_REPEAT_DEPTH         32
`define BC_REPEAT_AF_CUTOFF     (`BC_UPSTREAM_STALL_LAT + 5)   // covers the words in flight
`define BC_CTRL_DEPTH           64
`define BC_CTRL_AF_CUTOFF       1       // the repeater writes in the same cycle it sees space
`define BC_TIMEOUT_CYCLES       8       // idle cycles before a held word is released

`endif

//--- rtl/bc_addr_pkg.sv
/* address and burst count types */
`include "burst_coal_cfg.svh"

package bc_addr_pkg;

    // one memory word address, the byte offset is added outside the coalescer
    typedef logic [`BC_WORD_ADDR_W-1:0] word_addr_t;

    // Avalon burst count, a value of 1 means a single word
    typedef logic [`BC_BURSTCOUNT_W-1:0] burstcount_t;

endpackage

//--- rtl/bc_ctrl_pkg.sv
/* state encodings of the burst builder and the repeater */
package bc_ctrl_pkg;

    // builder holds at most one word while waiting for the next one
    typedef enum logic {
        CAPT_EMPTY,
        CAPT_HELD
    } capt_state_e;

    // repeater is idle on the first copy of every burst
    typedef enum logic {
        REP_IDLE,
        REP_IN_BURST
    } rep_state_e;

endpackage

//--- rtl/word_addr_adder.sv
/* two-stage split adder for base address plus offset */
`timescale 1ns/1ps
`include "burst_coal_cfg.svh"

module word_addr_adder
    import bc_addr_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    aclrn,
    input  logic                                    i_valid,
    input  word_addr_t                              i_base_addr,
    input  logic [1:0]                              i_add_to_base_addr,
    output logic                                    o_valid,      // aligned with o_addr_lo
    output logic [`BC_TESS_INDEX-1:0]               o_addr_lo,
    output logic [`BC_WORD_ADDR_W-1:`BC_TESS_INDEX] o_addr_hi     // one cycle after o_addr_lo
);

    localparam int HI_W = `BC_WORD_ADDR_W - `BC_TESS_INDEX;

    logic [`BC_TESS_INDEX:0] sum_lo;     // low half of the sum, top bit is the carry out
    logic [HI_W-1:0]         base_hi;    // upper half of the base, waiting for the carry

    // valid tracks the low half so the builder can start comparing early
    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clock) begin
        // first stage adds the offset into the low half only
        sum_lo  <= i_base_addr[`BC_TESS_INDEX-1:0] + (`BC_TESS_INDEX + 1)'(i_add_to_base_addr);
        base_hi <= i_base_addr[`BC_WORD_ADDR_W-1:`BC_TESS_INDEX];
        // second stage ripples the carry into the high half
        o_addr_hi <= base_hi + HI_W'(sum_lo[`BC_TESS_INDEX]);
    end

    assign o_addr_lo = sum_lo[`BC_TESS_INDEX-1:0];    // carry is kept internal

endmodule

//--- rtl/burst_builder.sv
/* burst builder: word capture, split address compare, idle timeout
   and burst length accumulation */
`timescale 1ns/1ps
`include "burst_coal_cfg.svh"

module burst_builder
    import bc_addr_pkg::*;
    import bc_ctrl_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    aclrn,
    input  logic                                    i_valid,
    input  logic [`BC_TESS_INDEX-1:0]               i_addr_lo,    // same cycle as i_valid
    input  logic [`BC_WORD_ADDR_W-1:`BC_TESS_INDEX] i_addr_hi,    // one cycle after i_valid
    input  logic                                    i_disable_timeout,
    output logic                                    o_burst_valid,
    output word_addr_t                              o_burst_addr,
    output burstcount_t                             o_burst_count
);

    localparam int BB   = $clog2(`BC_MAX_BURST);        // address bits inside one burst
    localparam int TO_W = $clog2(`BC_TIMEOUT_CYCLES);
    localparam int HI_W = `BC_WORD_ADDR_W - `BC_TESS_INDEX;

    ////////////////////////////////////////////////////////////////////
    // capture of the most recent word

    capt_state_e               capt_state;
    logic [`BC_TESS_INDEX-1:0] capt_lo;
    logic [BB-1:0]             capt_next_in_burst;   // low bits of the expected next word
    logic                      capt_not_at_bound;    // next word would still be inside the burst
    logic [HI_W-1:0]           capt_hi;
    logic [`BC_TESS_INDEX-1:0] capt_next_lo;
    logic                      late_valid;
    logic                      held;

    // compare and release pipeline
    logic                      cont_valid;           // stage 1, new word may extend the burst
    logic                      late_cont_valid;
    logic                      match_lo;             // stage 1, low half matches
    logic                      late_match;           // stage 2, full address matches
    logic                      coal_continue;
    logic                      late_done;
    logic [`BC_TESS_INDEX-1:0] late_capt_lo;
    logic                      coal_done;            // the old word leaves the capture
    word_addr_t                coal_addr;

    // timeout and accumulator
    logic [TO_W-1:0]           idle_cnt;
    logic                      timeout;
    logic                      add_one;
    logic                      load_next;            // next released word starts a new burst

    assign held = (capt_state == CAPT_HELD);

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            capt_state <= CAPT_EMPTY;
        end else if (i_valid) begin
            capt_state <= CAPT_HELD;
        end else if (timeout) begin
            capt_state <= CAPT_EMPTY;    // the word was flushed on its own
        end
    end

    always_ff @(posedge clock) begin
        if (i_valid) begin
            capt_lo            <= i_addr_lo;
            capt_next_in_burst <= i_addr_lo[BB-1:0] + 1'b1;
            capt_not_at_bound  <= ~&i_addr_lo[BB-1:0];    // last word before the boundary
        end
        if (late_valid) begin
            capt_hi <= i_addr_hi;    // high half arrives one cycle behind
        end
        match_lo     <= (i_addr_lo == capt_next_lo);
        late_match   <= match_lo & (i_addr_hi == capt_hi);    // capt_hi still holds the old word
        late_capt_lo <= capt_lo;
        coal_addr    <= {capt_hi, late_capt_lo};
    end

    // bits above the burst field never change inside a burst
    assign capt_next_lo  = {capt_lo[`BC_TESS_INDEX-1:BB], capt_next_in_burst};
    assign coal_continue = late_match & late_cont_valid;

    ////////////////////////////////////////////////////////////////////
    // idle timeout, frozen while the control queue is well stocked

    assign timeout = held & ~i_valid & ~i_disable_timeout &
                     (idle_cnt == TO_W'(`BC_TIMEOUT_CYCLES - 1));

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            idle_cnt <= '0;
        end else if (i_valid || !held) begin
            idle_cnt <= '0;
        end else if (!i_disable_timeout) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // burst accumulator, flushed when the released word does not continue

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            late_valid      <= 1'b0;
            cont_valid      <= 1'b0;
            late_cont_valid <= 1'b0;
            late_done       <= 1'b0;
            coal_done       <= 1'b0;
            o_burst_valid   <= 1'b0;
            add_one         <= 1'b0;
            load_next       <= 1'b1;    // the very first word opens a burst
            o_burst_count   <= burstcount_t'(1);
        end else begin
            late_valid      <= i_valid;
            cont_valid      <= i_valid & held & capt_not_at_bound;
            late_cont_valid <= cont_valid;
            late_done       <= timeout | (i_valid & held);    // old word is done either way
            coal_done       <= late_done;
            o_burst_valid   <= coal_done & ~coal_continue;
            add_one         <= coal_done & coal_continue;
            if (coal_done) begin
                load_next <= ~coal_continue;
            end
            // the count seen with the write pulse is the old one
            if (o_burst_valid) begin
                o_burst_count <= burstcount_t'(1);
            end
            if (add_one) begin
                o_burst_count <= o_burst_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (coal_done && load_next) begin
            o_burst_addr <= coal_addr;    // start address of the burst
        end
    end

endmodule

//--- rtl/show_ahead_fifo.sv
/* show-ahead register FIFO with empty and almost-full flags */
`timescale 1ns/1ps

module show_ahead_fifo #(
    parameter int WIDTH     = 8,
    parameter int DEPTH     = 16,    // a power of two so the pointers wrap on their own
    parameter int AF_CUTOFF = 1      // almost-full once free space is at or below this
) (
    input  logic             clock,
    input  logic             aclrn,
    input  logic             i_wr_req,
    input  logic [WIDTH-1:0] i_wr_data,
    input  logic             i_rd_ack,     // pops the head, only while not empty
    output logic [WIDTH-1:0] o_rd_data,    // head entry, valid while not empty
    output logic             o_empty,
    output logic             o_almost_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;    // occupancy, both flags derive from it

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr_req) wr_ptr <= wr_ptr + 1'b1;
            if (i_rd_ack) rd_ptr <= rd_ptr + 1'b1;
            if (i_wr_req && !i_rd_ack) begin
                count <= count + 1'b1;
            end else if (!i_wr_req && i_rd_ack) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (i_wr_req) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    assign o_rd_data     = mem[rd_ptr];    // head is visible before the read
    assign o_empty       = (count == '0);  // one cycle after the first write
    assign o_almost_full = (count >= CNT_W'(DEPTH - AF_CUTOFF));

endmodule

//--- rtl/burst_repeater.sv
/* repeater that writes one control entry per word of each burst */
`timescale 1ns/1ps

module burst_repeater
    import bc_addr_pkg::*;
    import bc_ctrl_pkg::*;
(
    input  logic        clock,
    input  logic        aclrn,
    input  logic        i_rep_empty,
    input  word_addr_t  i_rep_addr,
    input  burstcount_t i_rep_count,
    output logic        o_rep_rd_ack,       // pops the burst on its last copy
    input  logic        i_ctrl_almost_full,
    output logic        o_ctrl_wr_req,
    output word_addr_t  o_ctrl_addr,
    output burstcount_t o_ctrl_count
);

    rep_state_e  state;
    burstcount_t remaining;       // copies left, counting the one written now
    logic        remaining_eq_two;
    logic        go;              // a copy is written this cycle
    logic        is_last;

    assign go      = ~i_rep_empty & ~i_ctrl_almost_full;
    // a burst of one never enters the burst state and is popped at once
    assign is_last = (state == REP_IN_BURST) ? remaining_eq_two
                                             : (i_rep_count == burstcount_t'(1));

    assign o_rep_rd_ack  = go & is_last;
    assign o_ctrl_wr_req = go;           // write and state update share the cycle
    assign o_ctrl_addr   = i_rep_addr;   // every copy carries the burst start
    assign o_ctrl_count  = i_rep_count;

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            state            <= REP_IDLE;
            remaining        <= '0;
            remaining_eq_two <= 1'b0;
        end else if (go) begin
            if (state == REP_IDLE) begin
                remaining        <= i_rep_count;
                remaining_eq_two <= (i_rep_count == burstcount_t'(2));
                if (i_rep_count != burstcount_t'(1)) state <= REP_IN_BURST;
            end else begin
                remaining        <= remaining - 1'b1;
                remaining_eq_two <= (remaining == burstcount_t'(3));    // true one copy ahead
                if (remaining_eq_two) state <= REP_IDLE;
            end
        end
    end

endmodule

//--- rtl/ctrl_queue.sv
/* control FIFO with occupancy tracking and the timeout-disable flag */
`timescale 1ns/1ps
`include "burst_coal_cfg.svh"

module ctrl_queue
    import bc_addr_pkg::*;
(
    input  logic        clock,
    input  logic        aclrn,
    input  logic        i_wr_req,
    input  word_addr_t  i_wr_addr,
    input  burstcount_t i_wr_count,
    input  logic        i_rd_ack,
    output logic        o_empty,
    output word_addr_t  o_rd_addr,
    output burstcount_t o_rd_count,
    output logic        o_almost_full,
    output logic        o_disable_timeout    // queue at least half full
);

    localparam int OCC_W = $clog2(`BC_CTRL_DEPTH + 1);

    logic [1:0]       occ_update;    // +1, 0 or -1 in two's complement
    logic [OCC_W-1:0] occ;           // trails the FIFO by one cycle

    show_ahead_fifo #(
        .WIDTH     (`BC_BURSTCOUNT_W + `BC_WORD_ADDR_W),
        .DEPTH     (`BC_CTRL_DEPTH),
        .AF_CUTOFF (`BC_CTRL_AF_CUTOFF)
    ) u_fifo (
        .clock         (clock),
        .aclrn         (aclrn),
        .i_wr_req      (i_wr_req),
        .i_wr_data     ({i_wr_count, i_wr_addr}),
        .i_rd_ack      (i_rd_ack),
        .o_rd_data     ({o_rd_count, o_rd_addr}),
        .o_empty       (o_empty),
        .o_almost_full (o_almost_full)
    );

    // both or neither leave the count alone
    assign occ_update = (i_wr_req && !i_rd_ack) ? 2'b01 :
                        (!i_wr_req && i_rd_ack) ? 2'b11 : 2'b00;

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            occ               <= '0;
            o_disable_timeout <= 1'b0;
        end else begin
            occ <= occ + {{(OCC_W - 1){occ_update[1]}}, occ_update[0]};
            // flag follows the tracked occupancy, set from half the queue upward
            o_disable_timeout <= (occ >= OCC_W'(`BC_CTRL_DEPTH / 2));
        end
    end

endmodule

//--- rtl/burst_coalescer.sv
/* top level of the write-path burst coalescer, adder through
   control queue */
`timescale 1ns/1ps
`include "burst_coal_cfg.svh"

module burst_coalescer
    import bc_addr_pkg::*;
(
    input  logic        clock,
    input  logic        aclrn,
    input  logic        i_valid,
    input  word_addr_t  i_base_addr,
    input  logic [1:0]  i_add_to_base_addr,
    output logic        o_almost_full,        // repeat FIFO is nearly full, upstream must stop
    output logic        o_ctrl_empty,
    input  logic        i_ctrl_rd_ack,
    output word_addr_t  o_word_address,
    output burstcount_t o_burstcount,
    output logic        o_disable_timeout
);

    // adder to builder
    logic                                    addr_valid;
    logic [`BC_TESS_INDEX-1:0]               addr_lo;
    logic [`BC_WORD_ADDR_W-1:`BC_TESS_INDEX] addr_hi;

    // builder to repeat FIFO, written without a stall
    logic        burst_valid;
    word_addr_t  burst_addr;
    burstcount_t burst_count;

    // repeat FIFO to repeater
    logic        rep_empty;
    logic        rep_rd_ack;
    word_addr_t  rep_addr;
    burstcount_t rep_count;

    // repeater to control queue
    logic        ctrl_wr_req;
    word_addr_t  ctrl_addr;
    burstcount_t ctrl_count;
    logic        ctrl_almost_full;

    word_addr_adder u_adder (
        .clock (clock), .aclrn (aclrn),
        .i_valid (i_valid), .i_base_addr (i_base_addr), .i_add_to_base_addr (i_add_to_base_addr),
        .o_valid (addr_valid), .o_addr_lo (addr_lo), .o_addr_hi (addr_hi)
    );

    burst_builder u_builder (
        .clock (clock), .aclrn (aclrn),
        .i_valid (addr_valid), .i_addr_lo (addr_lo), .i_addr_hi (addr_hi),
        .i_disable_timeout (o_disable_timeout),
        .o_burst_valid (burst_valid), .o_burst_addr (burst_addr), .o_burst_count (burst_count)
    );

    // one entry per burst, the cutoff absorbs every word still in the pipeline
    show_ahead_fifo #(
        .WIDTH     (`BC_BURSTCOUNT_W + `BC_WORD_ADDR_W),
        .DEPTH     (`BC_REPEAT_DEPTH),
        .AF_CUTOFF (`BC_REPEAT_AF_CUTOFF)
    ) u_repeat_fifo (
        .clock (clock), .aclrn (aclrn),
        .i_wr_req (burst_valid), .i_wr_data ({burst_count, burst_addr}),
        .i_rd_ack (rep_rd_ack), .o_rd_data ({rep_count, rep_addr}),
        .o_empty (rep_empty), .o_almost_full (o_almost_full)
    );

    burst_repeater u_repeater (
        .clock (clock), .aclrn (aclrn),
        .i_rep_empty (rep_empty), .i_rep_addr (rep_addr), .i_rep_count (rep_count),
        .o_rep_rd_ack (rep_rd_ack), .i_ctrl_almost_full (ctrl_almost_full),
        .o_ctrl_wr_req (ctrl_wr_req), .o_ctrl_addr (ctrl_addr), .o_ctrl_count (ctrl_count)
    );

    ctrl_queue u_ctrl_queue (
        .clock (clock), .aclrn (aclrn),
        .i_wr_req (ctrl_wr_req), .i_wr_addr (ctrl_addr), .i_wr_count (ctrl_count),
        .i_rd_ack (i_ctrl_rd_ack), .o_empty (o_ctrl_empty),
        .o_rd_addr (o_word_address), .o_rd_count (o_burstcount),
        .o_almost_full (ctrl_almost_full), .o_disable_timeout (o_disable_timeout)
    );

endmodule

//--- bench/clock_gen.sv
/* testbench clock of 10 ns and the power-on reset pulse */
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic aclrn
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;    // 10 ns period
    end

    // reset held low for 8 rising edges, released away from the active edge
    initial begin
        aclrn = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        aclrn = 1'b1;
    end

endmodule

//--- bench/tb_burst_coalescer.sv
/* testbench of the burst coalescer: random stimulus, burst model,
   random sink, watchdog and report */
`timescale 1ns/1ps
`include "burst_coal_cfg.svh"

module tb_burst_coalescer
    import bc_addr_pkg::*;
();

    localparam int T2_GROUPS = 10;
    localparam int T3_GROUPS = 8;
    localparam int T4_WORDS  = 12;
    localparam int T5_WORDS  = 200;
    // upper bound on the words of all tests, the watchdog allows 40 cycles each
    localparam int MAX_WORDS = T2_GROUPS * 3 * 32 + T3_GROUPS * 2 * 40 + T4_WORDS + T5_WORDS;
    localparam int ENTRY_W   = `BC_BURSTCOUNT_W + `BC_WORD_ADDR_W;

    logic        clock;
    logic        aclrn;
    logic        i_valid;
    word_addr_t  i_base_addr;
    logic [1:0]  i_add_to_base_addr;
    logic        i_ctrl_rd_ack = 1'b0;
    logic        o_almost_full;
    logic        o_ctrl_empty;
    word_addr_t  o_word_address;
    burstcount_t o_burstcount;
    logic        o_disable_timeout;

    logic [ENTRY_W-1:0] exp_q[$];     // expected entries, {count, start address}
    word_addr_t         stim_addr[$]; // word addresses of the current stimulus
    logic [1:0]         stim_off[$];  // offset that the adder puts on each word
    integer             seed = 32'hc75d;
    integer             sink_seed;
    int                 err_count = 0;
    int                 check_count = 0;
    int                 pop_count = 0;
    logic               sink_en = 1'b1;

    clock_gen u_clock_gen (.clock (clock), .aclrn (aclrn));

    burst_coalescer DUT (
        .clock (clock), .aclrn (aclrn),
        .i_valid (i_valid), .i_base_addr (i_base_addr), .i_add_to_base_addr (i_add_to_base_addr),
        .o_almost_full (o_almost_full),
        .o_ctrl_empty (o_ctrl_empty), .i_ctrl_rd_ack (i_ctrl_rd_ack),
        .o_word_address (o_word_address), .o_burstcount (o_burstcount),
        .o_disable_timeout (o_disable_timeout)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("FAIL %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
            err_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model, one burst of length B gives B identical entries

    task automatic push_burst(input word_addr_t start, input int len);
        for (int k = 0; k < len; k++) exp_q.push_back({burstcount_t'(len), start});
    endtask

    // words arrive on back-to-back cycles, so only the address decides a break
    task automatic model_bursts();
        word_addr_t start;
        word_addr_t prev;
        int         len;
        len = 0;
        foreach (stim_addr[i]) begin
            if (len != 0 && (stim_addr[i] != word_addr_t'(prev + 1) ||
                             (prev % `BC_MAX_BURST) == `BC_MAX_BURST - 1)) begin
                push_burst(start, len);    // not sequential, or the boundary was hit
                len = 0;
            end
            if (len == 0) start = stim_addr[i];
            len++;
            prev = stim_addr[i];
        end
        if (len != 0) push_burst(start, len);    // the last word leaves by timeout
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus, all inputs change on the falling edge

    task automatic add_run(input word_addr_t start, input int len, input bit use_offset);
        logic [1:0] off;
        for (int k = 0; k < len; k++) begin
            off = use_offset ? 2'(1 + ($unsigned($random(seed)) % 3)) : 2'd0;
            stim_addr.push_back(word_addr_t'(start + k));
            stim_off.push_back(off);
        end
    endtask

    task automatic drive_stim();
        foreach (stim_addr[i]) begin
            @(negedge clock);
            while (o_almost_full) begin    // upstream holds off while the repeat FIFO is full
                i_valid = 1'b0;
                @(negedge clock);
            end
            i_valid            = 1'b1;
            i_add_to_base_addr = stim_off[i];
            i_base_addr        = stim_addr[i] - word_addr_t'(stim_off[i]);    // adder restores it
        end
        @(negedge clock);
        i_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || !o_ctrl_empty) @(negedge clock);
        repeat (4) @(negedge clock);
    endtask

    task automatic run_stim();
        model_bursts();
        drive_stim();
        wait_drain();
        stim_addr.delete();
        stim_off.delete();
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s finished with %0d errors, %0d entries popped so far",
                 num, name, err_count - errs_before, pop_count);
    endtask

    // sink pops the head on random cycles and checks it against the model
    always @(negedge clock) begin : sink
        logic [ENTRY_W-1:0] head;
        i_ctrl_rd_ack = 1'b0;
        if (aclrn && sink_en && !o_ctrl_empty && ($random(sink_seed) & 1) == 1) begin
            if (exp_q.size() == 0) begin
                $display("at %0d ns the DUT produced an entry that the model does not expect",
                         $time);
                err_count++;
            end else begin
                head = exp_q.pop_front();
                check_value(32'(o_word_address), 32'(head[`BC_WORD_ADDR_W-1:0]), "word address");
                check_value(32'(o_burstcount), 32'(head[ENTRY_W-1:`BC_WORD_ADDR_W]), "burstcount");
            end
            i_ctrl_rd_ack = 1'b1;
            pop_count++;
        end
    end

    initial begin : watchdog
        #(MAX_WORDS * 40 * 10);
        $display("the run did not finish within %0d cycles, the DUT stopped making progress",
                 MAX_WORDS * 40);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : main
        int nruns;
        int errs;
        word_addr_t start;
        i_valid            = 1'b0;
        i_base_addr        = '0;
        i_add_to_base_addr = 2'd0;
        sink_seed          = $random(seed);    // the sink draws from its own sequence

        // test 1, flags during and right after reset
        errs = err_count;
        @(negedge clock);
        check_value(o_ctrl_empty, 1, "o_ctrl_empty in reset");
        check_value(o_almost_full, 0, "o_almost_full in reset");
        check_value(o_disable_timeout, 0, "o_disable_timeout in reset");
        wait (aclrn === 1'b1);
        @(negedge clock);
        check_value(o_ctrl_empty, 1, "o_ctrl_empty after reset");
        check_value(o_almost_full, 0, "o_almost_full after reset");
        check_value(o_disable_timeout, 0, "o_disable_timeout after reset");
        report_test(1, "reset state", errs);

        // test 2, groups of sequential runs back to back with a zero offset
        errs = err_count;
        for (int g = 0; g < T2_GROUPS; g++) begin
            nruns = 2 + ($unsigned($random(seed)) % 2);
            for (int r = 0; r < nruns; r++) begin
                add_run(word_addr_t'($random(seed)), 1 + ($unsigned($random(seed)) % 32), 1'b0);
            end
            run_stim();
        end
        report_test(2, "sequential runs", errs);

        // test 3, low byte starts near the top so the offset carries across the cut
        errs = err_count;
        for (int g = 0; g < T3_GROUPS; g++) begin
            for (int r = 0; r < 2; r++) begin
                start = word_addr_t'($random(seed)) | word_addr_t'(16'h00e0);
                add_run(start, 8 + ($unsigned($random(seed)) % 33), 1'b1);
            end
            run_stim();
        end
        report_test(3, "offsets across the adder cut", errs);

        // test 4, sequential words far apart each leave as a burst of one
        errs = err_count;
        start = word_addr_t'($random(seed));
        for (int w = 0; w < T4_WORDS; w++) begin
            add_run(word_addr_t'(start + w), 1, 1'b1);
            run_stim();
            repeat (`BC_TIMEOUT_CYCLES + 11) @(negedge clock);
        end
        report_test(4, "isolated words", errs);

        // test 5, sink stopped while a long sequential stream goes in
        errs = err_count;
        sink_en = 1'b0;
        add_run(word_addr_t'($random(seed)), T5_WORDS, 1'b0);
        model_bursts();
        drive_stim();
        repeat (20) @(negedge clock);
        check_value(o_disable_timeout, 1, "o_disable_timeout with a full queue");
        check_value(o_ctrl_empty, 0, "o_ctrl_empty with a stopped sink");
        sink_en = 1'b1;
        wait_drain();
        stim_addr.delete();
        stim_off.delete();
        repeat (30) @(negedge clock);
        check_value(o_ctrl_empty, 1, "o_ctrl_empty after the drain");
        check_value(o_disable_timeout, 0, "o_disable_timeout after the drain");
        report_test(5, "back-pressure", errs);

        $display("tests run 5, checks %0d, entries popped %0d, errors %0d",
                 check_count, pop_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- burst_coal.f
+incdir+rtl
rtl/bc_addr_pkg.sv
rtl/bc_ctrl_pkg.sv
rtl/word_addr_adder.sv
rtl/burst_builder.sv
rtl/show_ahead_fifo.sv
rtl/burst_repeater.sv
rtl/ctrl_queue.sv
rtl/burst_coalescer.sv
bench/clock_gen.sv
bench/tb_burst_coalescer.sv

//--- Makefile
# Verilator build and run of the burst coalescer testbench

TOP := tb_burst_coalescer

SRCS := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

# the binary is rebuilt only when the file list or a source changes
obj_dir/V$(TOP): burst_coal.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f burst_coal.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@$(MAKE) --no-print-directory check

# pass or fail comes from the log alone
check:
	@grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" || \
		(echo "simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: run check clean
